// ==== rtl/frv_consts.svh ====
/*
 * Machine timer and trap constants
 * MMIO window of the timer, its register offsets, the interrupt
 * cause codes and the reset value of mtimecmp
 */

`ifndef FRV_CONSTS_SVH
`define FRV_CONSTS_SVH

// ---------------------------------------------------------------------------
// MMIO window
// ---------------------------------------------------------------------------

`define FRV_MMIO_BASE_ADDR   32'h0000_1000 // Timer region base
`define FRV_MMIO_BASE_MASK   32'hFFFF_F000 // Bits that select the region

// Word offsets inside the window
`define FRV_MTIME_LO         32'h0000_0000 // mtime bits 31..0
`define FRV_MTIME_HI         32'h0000_0004 // mtime bits 63..32
`define FRV_MTIMECMP_LO      32'h0000_0008 // mtimecmp bits 31..0
`define FRV_MTIMECMP_HI      32'h0000_000C // mtimecmp bits 63..32

// ---------------------------------------------------------------------------
// Trap causes
// ---------------------------------------------------------------------------

`define FRV_CAUSE_NMI        6'd0          // Non-maskable interrupt
`define FRV_CAUSE_MSI        6'd3          // Machine software interrupt
`define FRV_CAUSE_MTI        6'd7          // Machine timer interrupt
`define FRV_CAUSE_MEI_BASE   6'd16         // Plus the 4-bit external code

// Compare value out of reach, no timer interrupt after reset
`define FRV_MTIMECMP_RESET   64'hFFFF_FFFF_FFFF_FFFF

`endif

// ==== rtl/frv_counters.sv ====
/*
 * Performance counters and machine timer
 * Cycle, mtime and instret counters, the mtimecmp register and the
 * MMIO decode of the timer window. Raises timer pending.
 */

`timescale 1ns/10ps

`include "frv_consts.svh"

module frv_counters import frv_csr_pkg::*; (
  input  logic      g_clk,       // Global clock
  input  logic      arst_n,      // Async reset, active low
  input  logic      instr_ret,   // Instruction retired
  input  inhibit_t  inhibit,     // Counter inhibit bits
  input  mmio_req_t mmio_req,    // Timer MMIO request
  output mmio_rsp_t mmio_rsp,    // Timer MMIO response
  output counters_t counters,    // Counter values
  output logic      ti_pending   // mtime has reached mtimecmp
);

  ctr_t  ctr_cycle;              // Cycle counter
  ctr_t  ctr_time;               // mtime
  ctr_t  ctr_instret;            // Retired count
  ctr_t  mtimecmp;               // Timer compare value

  xlen_t offset;                 // Address inside the window
  logic  in_window;              // Address hits the timer region
  logic  sel_time_lo;
  logic  sel_time_hi;
  logic  sel_cmp_lo;
  logic  sel_cmp_hi;
  logic  mapped;                 // One of the four registers
  logic  wr_en;                  // Enabled write
  xlen_t rd_mux;                 // Selected register half

  // ---------------------------------------------------------------------------
  // MMIO decode
  // ---------------------------------------------------------------------------

  assign in_window   = (mmio_req.addr & `FRV_MMIO_BASE_MASK) == `FRV_MMIO_BASE_ADDR;
  assign offset      = mmio_req.addr & ~`FRV_MMIO_BASE_MASK;
  assign sel_time_lo = in_window && (offset == `FRV_MTIME_LO);
  assign sel_time_hi = in_window && (offset == `FRV_MTIME_HI);
  assign sel_cmp_lo  = in_window && (offset == `FRV_MTIMECMP_LO);
  assign sel_cmp_hi  = in_window && (offset == `FRV_MTIMECMP_HI);
  assign mapped      = sel_time_lo || sel_time_hi || sel_cmp_lo || sel_cmp_hi;
  assign wr_en       = mmio_req.en && mmio_req.wen;

  always_comb begin
    rd_mux = '0;                                 // Unmapped reads as zero
    if (sel_time_lo) rd_mux = ctr_time[31:0];
    if (sel_time_hi) rd_mux = ctr_time[63:32];
    if (sel_cmp_lo)  rd_mux = mtimecmp[31:0];
    if (sel_cmp_hi)  rd_mux = mtimecmp[63:32];
  end

  assign mmio_rsp.rdata = mmio_req.en ? rd_mux : '0; // Quiet when idle
  assign mmio_rsp.error = mmio_req.en && !mapped;

  // ---------------------------------------------------------------------------
  // Counters and compare register
  // ---------------------------------------------------------------------------

  always_ff @(posedge g_clk or negedge arst_n) begin
    if (!arst_n) begin
      ctr_cycle   <= '0;
      ctr_time    <= '0;
      ctr_instret <= '0;
      mtimecmp    <= `FRV_MTIMECMP_RESET;
    end else begin
      if (!inhibit.cy)
        ctr_cycle <= ctr_cycle + 64'd1;
      if (instr_ret && !inhibit.ir)
        ctr_instret <= ctr_instret + 64'd1;
      // Software write wins over the tick
      if (wr_en && sel_time_lo)
        ctr_time <= {ctr_time[63:32], mmio_req.wdata};
      else if (wr_en && sel_time_hi)
        ctr_time <= {mmio_req.wdata, ctr_time[31:0]};
      else if (!inhibit.tm)
        ctr_time <= ctr_time + 64'd1;
      if (wr_en && sel_cmp_lo)
        mtimecmp[31:0]  <= mmio_req.wdata;
      if (wr_en && sel_cmp_hi)
        mtimecmp[63:32] <= mmio_req.wdata;
    end
  end

  assign ti_pending = ctr_time >= mtimecmp;      // Level, not a pulse
  assign counters   = '{mtime: ctr_time, cycle: ctr_cycle, instret: ctr_instret};

  // ---------------------------------------------------------------------------
  // Assertions
  // ---------------------------------------------------------------------------

  a_cycle_step : assert property (@(posedge g_clk) disable iff (!arst_n)
    !inhibit.cy |=> ctr_cycle == $past(ctr_cycle) + 64'd1)
    else $error("cycle counter did not advance by one");

  // Bad access leaves timer state alone, only the tick moves mtime
  a_err_no_write : assert property (@(posedge g_clk) disable iff (!arst_n)
    mmio_rsp.error |=> (mtimecmp == $past(mtimecmp)) &&
      (ctr_time == $past(ctr_time) + {63'd0, !$past(inhibit.tm)}))
    else $error("MMIO error access changed timer state");

endmodule

// ==== rtl/frv_csr_pkg.sv ====
/*
 * Counter and MMIO types
 * Data word, 64-bit counter values, inhibit bits and the request and
 * response of the timer MMIO port
 */

package frv_csr_pkg;

  typedef logic [31:0] xlen_t;  // Data word
  typedef logic [63:0] ctr_t;   // Counter value

  // Counter inhibit controls, one per counter
  typedef struct packed {
    logic cy;                   // Hold the cycle counter
    logic tm;                   // Hold mtime
    logic ir;                   // Hold instret
  } inhibit_t;

  // MMIO request from the load/store side
  typedef struct packed {
    logic  en;                  // Access valid this cycle
    logic  wen;                 // Write, else read
    xlen_t addr;                // Byte address
    xlen_t wdata;               // Write data
  } mmio_req_t;

  // MMIO response, same cycle as the request
  typedef struct packed {
    xlen_t rdata;               // Read data
    logic  error;               // Unmapped access
  } mmio_rsp_t;

  // Counter values seen by the CSR file
  typedef struct packed {
    ctr_t mtime;                // Machine timer
    ctr_t cycle;                // Clock cycles
    ctr_t instret;              // Retired instructions
  } counters_t;

endpackage

// ==== rtl/frv_interrupt_pending.sv ====
/*
 * Interrupt pending registers
 * Samples the interrupt source levels into mip and the NMI pending bit,
 * and holds the cause code of the last external interrupt
 */

`timescale 1ns/10ps

module frv_interrupt_pending import frv_irq_pkg::*; (
  input  logic       g_clk,            // Global clock
  input  logic       arst_n,           // Async reset, active low
  input  logic       int_nmi,          // Non-maskable interrupt line
  input  logic       int_external,     // External interrupt line
  input  ext_cause_t int_extern_cause, // External cause code
  input  logic       int_software,     // Software interrupt line
  input  logic       ti_pending,       // From the timer compare
  output mip_t       mip,              // Pending bits
  output logic       nmi_pend,         // NMI pending
  output ext_cause_t ext_cause         // Cause paired with meip
);

  // ---------------------------------------------------------------------------
  // Pending bits, one cycle behind their sources
  // ---------------------------------------------------------------------------

  always_ff @(posedge g_clk or negedge arst_n) begin
    if (!arst_n) begin
      mip      <= '0;
      nmi_pend <= 1'b0;
    end else begin
      mip.meip <= int_external;
      mip.mtip <= ti_pending;
      mip.msip <= int_software;
      nmi_pend <= int_nmi;
    end
  end

  // Code follows the line while it is high, kept once it drops
  always_ff @(posedge g_clk) begin
    if (int_external)
      ext_cause <= int_extern_cause;
  end

endmodule

// ==== rtl/frv_irq_pkg.sv ====
/*
 * Interrupt types
 * Enable and pending bits, cause codes and the trap request FSM states
 */

package frv_irq_pkg;

  typedef logic [3:0] ext_cause_t;   // External interrupt code
  typedef logic [5:0] trap_cause_t;  // Cause handed to writeback

  // mstatus.MIE and the mie bits
  typedef struct packed {
    logic mstatus_mie;               // Global enable
    logic meie;                      // External enable
    logic mtie;                      // Timer enable
    logic msie;                      // Software enable
  } irq_en_t;

  // mip bits
  typedef struct packed {
    logic meip;                      // External pending
    logic mtip;                      // Timer pending
    logic msip;                      // Software pending
  } mip_t;

  // Trap request FSM
  typedef enum logic {
    IDLE,                            // No request outstanding
    REQ                              // Waiting for writeback ack
  } trap_state_e;

endpackage

// ==== rtl/frv_trap_arbiter.sv ====
/*
 * Interrupt trap arbiter
 * Masks the pending bits, picks one cause by priority and holds the
 * request to writeback until it is acknowledged
 */

`timescale 1ns/10ps

`include "frv_consts.svh"

module frv_trap_arbiter import frv_irq_pkg::*; (
  input  logic        g_clk,          // Global clock
  input  logic        arst_n,         // Async reset, active low
  input  irq_en_t     irq_en,         // Global and per-source enables
  input  mip_t        mip,            // Pending bits
  input  logic        nmi_pend,       // NMI pending, never masked
  input  ext_cause_t  ext_cause,      // External cause code
  input  logic        int_trap_ack,   // Writeback took the trap
  output logic        int_trap_req,   // Trap request to writeback
  output trap_cause_t int_trap_cause  // Cause of the request
);

  trap_state_e state_q;               // Request FSM
  trap_cause_t cause_q;               // Latched cause
  trap_cause_t cause_sel;             // Winner this cycle
  logic        mei_go;                // Enabled external
  logic        msi_go;                // Enabled software
  logic        mti_go;                // Enabled timer
  logic        any_go;                // Something to offer

  // ---------------------------------------------------------------------------
  // Masking and priority
  // ---------------------------------------------------------------------------

  assign mei_go = mip.meip && irq_en.meie && irq_en.mstatus_mie;
  assign msi_go = mip.msip && irq_en.msie && irq_en.mstatus_mie;
  assign mti_go = mip.mtip && irq_en.mtie && irq_en.mstatus_mie;
  assign any_go = nmi_pend || mei_go || msi_go || mti_go;

  // Later assignments win: NMI, external, software, timer
  always_comb begin
    cause_sel = `FRV_CAUSE_MTI;
    if (msi_go)
      cause_sel = `FRV_CAUSE_MSI;
    if (mei_go)
      cause_sel = `FRV_CAUSE_MEI_BASE + {2'b00, ext_cause};
    if (nmi_pend)
      cause_sel = `FRV_CAUSE_NMI;
  end

  // ---------------------------------------------------------------------------
  // Request FSM
  // ---------------------------------------------------------------------------

  always_ff @(posedge g_clk or negedge arst_n) begin
    if (!arst_n) begin
      state_q <= IDLE;
      cause_q <= '0;
    end else begin
      case (state_q)
        IDLE: if (any_go) begin
          state_q <= REQ;
          cause_q <= cause_sel;          // Frozen until the ack
        end
        REQ: if (int_trap_ack)
          state_q <= IDLE;               // One low cycle before the next
        default: state_q <= IDLE;
      endcase
    end
  end

  assign int_trap_req   = state_q == REQ;
  assign int_trap_cause = cause_q;

  // Writeback must see one cause for the whole request
  a_cause_stable : assert property (@(posedge g_clk) disable iff (!arst_n)
    int_trap_req && !int_trap_ack |=> int_trap_req && $stable(int_trap_cause))
    else $error("trap request dropped or cause changed before ack");

endmodule

// ==== rtl/frv_uncore.sv ====
/*
 * Machine timer and interrupt uncore
 * Counters and timer feed the pending registers, which feed the trap
 * arbiter facing the writeback stage
 */

`timescale 1ns/10ps

module frv_uncore import frv_csr_pkg::*, frv_irq_pkg::*; (
  input  logic        g_clk,            // Global clock
  input  logic        arst_n,           // Async reset, active low
  input  logic        instr_ret,        // Instruction retired
  input  inhibit_t    inhibit,          // Counter inhibit bits
  input  mmio_req_t   mmio_req,         // Timer MMIO request
  output mmio_rsp_t   mmio_rsp,         // Timer MMIO response
  output counters_t   counters,         // Counter values
  input  irq_en_t     irq_en,           // Interrupt enables
  input  logic        int_nmi,          // Non-maskable interrupt
  input  logic        int_external,     // External interrupt line
  input  ext_cause_t  int_extern_cause, // External cause code
  input  logic        int_software,     // Software interrupt line
  output mip_t        mip,              // Pending bits
  output logic        int_mtime,        // Timer interrupt pending
  output logic        int_trap_req,     // Trap request to writeback
  output trap_cause_t int_trap_cause,   // Cause of the request
  input  logic        int_trap_ack      // Writeback took the trap
);

  logic       ti_pending;               // Timer compare hit
  logic       nmi_pend;                 // Registered NMI
  ext_cause_t ext_cause;                // Held external code

  assign int_mtime = mip.mtip;

  frv_counters u_counters (
    .g_clk      (g_clk),
    .arst_n     (arst_n),
    .instr_ret  (instr_ret),
    .inhibit    (inhibit),
    .mmio_req   (mmio_req),
    .mmio_rsp   (mmio_rsp),
    .counters   (counters),
    .ti_pending (ti_pending)
  );

  frv_interrupt_pending u_pending (
    .g_clk            (g_clk),
    .arst_n           (arst_n),
    .int_nmi          (int_nmi),
    .int_external     (int_external),
    .int_extern_cause (int_extern_cause),
    .int_software     (int_software),
    .ti_pending       (ti_pending),
    .mip              (mip),
    .nmi_pend         (nmi_pend),
    .ext_cause        (ext_cause)
  );

  frv_trap_arbiter u_arbiter (
    .g_clk          (g_clk),
    .arst_n         (arst_n),
    .irq_en         (irq_en),
    .mip            (mip),
    .nmi_pend       (nmi_pend),
    .ext_cause      (ext_cause),
    .int_trap_ack   (int_trap_ack),
    .int_trap_req   (int_trap_req),
    .int_trap_cause (int_trap_cause)
  );

endmodule

// ==== sources.f ====
+incdir+rtl
rtl/frv_csr_pkg.sv
rtl/frv_irq_pkg.sv
rtl/frv_counters.sv
rtl/frv_interrupt_pending.sv
rtl/frv_trap_arbiter.sv
rtl/frv_uncore.sv
verification/frv_uncore_tb.sv

// ==== verification/frv_uncore_tb.sv ====
/*
 * Testbench of the machine timer and interrupt uncore
 * Drives the counters, the timer MMIO and the interrupt sources
 * Concurrent assertions compare the DUT with a small reference model
 */

`timescale 1ns/10ps

`include "frv_consts.svh"

module frv_uncore_tb import frv_csr_pkg::*, frv_irq_pkg::*; ();

  localparam int NUM_TESTS = 5;
  localparam int CLK_NS    = 100;

  logic g_clk, arst_n, instr_ret, int_nmi, int_external, int_software, int_trap_ack;
  inhibit_t inhibit;
  mmio_req_t mmio_req;
  mmio_rsp_t mmio_rsp;
  counters_t counters;
  irq_en_t irq_en;
  ext_cause_t int_extern_cause;
  mip_t mip;
  logic int_mtime, int_trap_req;
  trap_cause_t int_trap_cause;

  integer seed;                  // $random state
  integer rnd;
  int err_count;
  int test_count;
  int test_errs;                 // Errors before the current test
  ctr_t cmp_model;               // Expected mtimecmp
  ctr_t time_model;              // Expected mtime
  logic mmio_wr;                 // Write to a mapped register
  xlen_t wr_off;                 // Offset of the access
  logic nmi_q;                   // Expected NMI pending
  ext_cause_t ext_q;             // Expected held external code
  logic exp_go;                  // Arbiter should raise a request
  trap_cause_t exp_sel;          // Cause it should latch

  frv_uncore u_dut (.*);

  initial begin
    g_clk = 1'b0;
    forever #(CLK_NS / 2) g_clk = ~g_clk;
  end

  // --------------------------------------------------------------------------
  // Reference model from the register map and priority rules
  // --------------------------------------------------------------------------

  function automatic logic is_mapped(input xlen_t a);
    xlen_t off;
    off = a & ~`FRV_MMIO_BASE_MASK;
    return ((a & `FRV_MMIO_BASE_MASK) == `FRV_MMIO_BASE_ADDR) &&
      (off == `FRV_MTIME_LO || off == `FRV_MTIME_HI ||
       off == `FRV_MTIMECMP_LO || off == `FRV_MTIMECMP_HI);
  endfunction

  function automatic xlen_t exp_rdata(input xlen_t a, input ctr_t tm, input ctr_t cmp);
    if (!is_mapped(a)) return '0;
    case (a & ~`FRV_MMIO_BASE_MASK)
      `FRV_MTIME_LO:    return tm[31:0];
      `FRV_MTIME_HI:    return tm[63:32];
      `FRV_MTIMECMP_LO: return cmp[31:0];
      default:          return cmp[63:32];
    endcase
  endfunction

  assign mmio_wr = mmio_req.en && mmio_req.wen && is_mapped(mmio_req.addr);
  assign wr_off  = mmio_req.addr & ~`FRV_MMIO_BASE_MASK;

  always @(posedge g_clk or negedge arst_n) begin
    if (!arst_n) begin
      cmp_model  <= `FRV_MTIMECMP_RESET;
      time_model <= '0;
      nmi_q      <= 1'b0;
    end else begin
      nmi_q <= int_nmi;
      if (int_external) ext_q <= int_extern_cause;          // Held while low
      if (mmio_wr && wr_off == `FRV_MTIMECMP_LO)
        cmp_model[31:0] <= mmio_req.wdata;
      if (mmio_wr && wr_off == `FRV_MTIMECMP_HI)
        cmp_model[63:32] <= mmio_req.wdata;
      if (mmio_wr && wr_off == `FRV_MTIME_LO)                // Write beats the tick
        time_model[31:0] <= mmio_req.wdata;
      else if (mmio_wr && wr_off == `FRV_MTIME_HI)
        time_model[63:32] <= mmio_req.wdata;
      else if (!inhibit.tm)
        time_model <= time_model + 64'd1;
    end
  end

  always_comb begin
    exp_go  = 1'b1;
    exp_sel = `FRV_CAUSE_NMI;
    if (nmi_q) exp_sel = `FRV_CAUSE_NMI;                    // Never masked
    else if (irq_en.mstatus_mie && irq_en.meie && mip.meip)
      exp_sel = `FRV_CAUSE_MEI_BASE + {2'b00, ext_q};
    else if (irq_en.mstatus_mie && irq_en.msie && mip.msip) exp_sel = `FRV_CAUSE_MSI;
    else if (irq_en.mstatus_mie && irq_en.mtie && mip.mtip) exp_sel = `FRV_CAUSE_MTI;
    else exp_go = 1'b0;
  end

  // --------------------------------------------------------------------------
  // Assertions
  // --------------------------------------------------------------------------

  task automatic note_error(input string msg);
    err_count++;
    $display("Error: %0t ns: %s", $time, msg);
  endtask

  a_reset_vals : assert property (@(posedge g_clk) !arst_n && $past(!arst_n) |->
    counters == '0 && mip == '0 && !int_mtime && !int_trap_req && int_trap_cause == '0)
    else note_error("outputs not at reset values");
  a_cycle_inc : assert property (@(posedge g_clk) disable iff (!arst_n)
    !inhibit.cy |=> counters.cycle == $past(counters.cycle) + 64'd1)
    else note_error("cycle did not advance by one");
  a_cycle_hold : assert property (@(posedge g_clk) disable iff (!arst_n)
    inhibit.cy |=> $stable(counters.cycle)) else note_error("inhibited cycle moved");
  a_time_val : assert property (@(posedge g_clk) disable iff (!arst_n)
    counters.mtime == time_model) else note_error("mtime does not match its model");
  a_ret_inc : assert property (@(posedge g_clk) disable iff (!arst_n)
    instr_ret && !inhibit.ir |=> counters.instret == $past(counters.instret) + 64'd1)
    else note_error("instret did not count a retire");
  a_ret_hold : assert property (@(posedge g_clk) disable iff (!arst_n)
    !(instr_ret && !inhibit.ir) |=> $stable(counters.instret))
    else note_error("instret moved without a retire");
  a_rd_data : assert property (@(posedge g_clk) disable iff (!arst_n)
    mmio_req.en && !mmio_req.wen |->
      mmio_rsp.rdata == exp_rdata(mmio_req.addr, time_model, cmp_model))
    else note_error("MMIO read data mismatch");
  a_err_flag : assert property (@(posedge g_clk) disable iff (!arst_n)
    mmio_req.en |-> mmio_rsp.error == !is_mapped(mmio_req.addr))
    else note_error("MMIO error flag mismatch");
  a_idle_rsp : assert property (@(posedge g_clk) disable iff (!arst_n)
    !mmio_req.en |-> mmio_rsp == '0) else note_error("MMIO response not zero when idle");
  a_mtime_rise : assert property (@(posedge g_clk) disable iff (!arst_n)
    1'b1 |=> int_mtime == ($past(time_model) >= $past(cmp_model)))
    else note_error("int_mtime does not follow mtime >= mtimecmp");
  a_mip_follow : assert property (@(posedge g_clk) disable iff (!arst_n)
    1'b1 |=> mip.meip == $past(int_external) && mip.msip == $past(int_software))
    else note_error("mip bits do not follow their sources");
  a_req_raise : assert property (@(posedge g_clk) disable iff (!arst_n)
    !int_trap_req && exp_go |=> int_trap_req && int_trap_cause == $past(exp_sel))
    else note_error("trap request missing or wrong cause");
  a_req_quiet : assert property (@(posedge g_clk) disable iff (!arst_n)
    !int_trap_req && !exp_go |=> !int_trap_req && $stable(int_trap_cause))
    else note_error("trap request without enabled pending source");
  a_req_hold : assert property (@(posedge g_clk) disable iff (!arst_n)
    int_trap_req && !int_trap_ack |=> int_trap_req && $stable(int_trap_cause))
    else note_error("request or cause changed before ack");
  a_ack_drop : assert property (@(posedge g_clk) disable iff (!arst_n)
    int_trap_req && int_trap_ack |=> !int_trap_req)
    else note_error("request still high after ack");

  // --------------------------------------------------------------------------
  // Stimulus helpers
  // --------------------------------------------------------------------------

  task automatic tick();
    @(posedge g_clk);
    #1;                                                     // Drive after the edge
  endtask

  task automatic mmio_access(input logic wen, input xlen_t addr, input xlen_t wdata);
    mmio_req = '{en: 1'b1, wen: wen, addr: addr, wdata: wdata};
    tick();
    mmio_req = '0;
  endtask

  task automatic serve_trap();
    while (!int_trap_req) tick();
    rnd = $random(seed);
    repeat (1 + rnd[1:0]) tick();                           // Hold across a random delay
    int_trap_ack = 1'b1;
    tick();
    int_trap_ack = 1'b0;
  endtask

  task automatic end_test(input string name);
    test_count++;
    $display("Test %0d %s finished with %0d errors", test_count, name,
      err_count - test_errs);
    test_errs = err_count;
  endtask

  // --------------------------------------------------------------------------
  // Test sequence
  // --------------------------------------------------------------------------

  initial begin
    seed = 32'hd3504961;
    {arst_n, instr_ret, int_nmi, int_external, int_software, int_trap_ack} = '0;
    inhibit = '0;
    mmio_req = '0;
    irq_en = '0;
    int_extern_cause = '0;
    {err_count, test_count, test_errs} = '0;
    repeat (3) @(posedge g_clk);
    #1 arst_n = 1'b1;

    repeat (40) begin                                       // Counters
      rnd = $random(seed);
      instr_ret = rnd[3];
      inhibit = rnd[2:0];
      tick();
    end
    {instr_ret, inhibit} = '0;
    end_test("counters");

    mmio_access(1'b1, `FRV_MMIO_BASE_ADDR + `FRV_MTIMECMP_LO, $random(seed));
    mmio_access(1'b1, `FRV_MMIO_BASE_ADDR + `FRV_MTIMECMP_HI, $random(seed));
    mmio_access(1'b0, `FRV_MMIO_BASE_ADDR + `FRV_MTIMECMP_LO, '0);
    mmio_access(1'b0, `FRV_MMIO_BASE_ADDR + `FRV_MTIMECMP_HI, '0);
    mmio_access(1'b1, `FRV_MMIO_BASE_ADDR + 32'h10, 32'h5a5a_5a5a);   // Bad offset
    mmio_access(1'b1, 32'h0000_2008, 32'ha5a5_a5a5);                  // Outside window
    mmio_access(1'b0, `FRV_MMIO_BASE_ADDR + `FRV_MTIMECMP_LO, '0);
    mmio_access(1'b0, `FRV_MMIO_BASE_ADDR + `FRV_MTIME_LO, '0);
    tick();
    end_test("mmio");

    irq_en = '{mstatus_mie: 1'b1, meie: 1'b0, mtie: 1'b1, msie: 1'b0};
    mmio_access(1'b1, `FRV_MMIO_BASE_ADDR + `FRV_MTIMECMP_LO, 32'hFFFF_FFFF);
    mmio_access(1'b1, `FRV_MMIO_BASE_ADDR + `FRV_MTIMECMP_HI, counters.mtime[63:32]);
    mmio_access(1'b1, `FRV_MMIO_BASE_ADDR + `FRV_MTIMECMP_LO, counters.mtime[31:0] + 20);
    while (!int_trap_req) tick();
    mmio_access(1'b1, `FRV_MMIO_BASE_ADDR + `FRV_MTIMECMP_HI, 32'hFFFF_FFFF);
    repeat (2) tick();                                      // Let mtip drop
    serve_trap();
    irq_en = '0;
    end_test("timer");

    irq_en = '1;
    rnd = $random(seed);
    int_extern_cause = rnd[3:0];
    int_external = 1'b1;
    int_software = 1'b1;
    mmio_access(1'b1, `FRV_MMIO_BASE_ADDR + `FRV_MTIMECMP_HI, '0);    // Timer fires too
    serve_trap();
    int_nmi = 1'b1;
    serve_trap();
    serve_trap();
    int_nmi = 1'b0;
    irq_en.mstatus_mie = 1'b0;                              // Only NMI gets through
    repeat (2) tick();
    if (int_trap_req) serve_trap();
    repeat (8) tick();
    int_nmi = 1'b1;
    tick();
    int_nmi = 1'b0;
    serve_trap();
    {int_external, int_software} = '0;
    mmio_access(1'b1, `FRV_MMIO_BASE_ADDR + `FRV_MTIMECMP_HI, 32'hFFFF_FFFF);
    irq_en = '0;
    repeat (3) tick();
    end_test("priority");

    int_trap_ack = 1'b1;                                    // Stray ack without a request
    repeat (3) tick();
    int_trap_ack = 1'b0;
    irq_en = '{mstatus_mie: 1'b1, meie: 1'b0, mtie: 1'b0, msie: 1'b1};
    int_software = 1'b1;
    tick();
    int_software = 1'b0;
    serve_trap();
    irq_en = '0;
    repeat (3) tick();
    end_test("acknowledge");

    $display("Tests run: %0d, errors: %0d", test_count, err_count);
    if (err_count == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

  initial begin
    #(NUM_TESTS * 200 * CLK_NS);
    $display("Watchdog: the tests did not finish in time, run stopped");
    $display("Result: FAILED");
    $finish;
  end

endmodule
